// ==== build.f ====
+incdir+hdl
hdl/pdes_pkg.sv
hdl/event_source.sv
hdl/event_queue.sv
hdl/event_processor.sv
hdl/run_control.sv
hdl/pdes_top.sv
verification/pdes_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module pdes_tb -o pdes_sim

sim_out=$(./obj_dir/pdes_sim)
echo "$sim_out"

if grep -qx "STATUS: PASS" <<< "$sim_out"; then
   exit 0
else
   exit 1
fi

// ==== verification/pdes_cases.txt ====
# columns, all decimal: num_init_events lp_mask fixed_delay sim_end exp_events exp_gvt
# exp_events = num_init_events * (sim_end / fixed_delay + 1), exp_gvt = (sim_end / fixed_delay + 1) * fixed_delay
4 3 10 100 44 110
16 15 5 40 144 45
1 0 1 0 1 1
8 255 7 50 64 56
5 6 3 30 55 33
12 31 100 999 120 1000
3 1 9 8 3 9
16 7 250 2000 144 2250
2 128 1 20 42 21
7 15 4096 60000 105 61440

// ==== verification/pdes_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pdes_macros.svh"

module pdes_tb;

   logic                clk;
   logic                rst_n;
   logic                start;
   pdes_pkg::init_cnt_t num_init_events;
   pdes_pkg::lp_id_t    lp_mask;
   pdes_pkg::time_t     fixed_delay;
   pdes_pkg::time_t     sim_end;
   logic                evt_valid;
   pdes_pkg::event_t    evt;
   pdes_pkg::time_t     gvt;
   logic                done;
   logic                busy;
   pdes_pkg::count_t    total_events;
   pdes_pkg::count_t    total_cycles;

   // one entry per case line
   int cfg_num[$];
   int cfg_mask[$];
   int cfg_delay[$];
   int cfg_end[$];
   int exp_events[$];
   int exp_gvt[$];

   int value_errors;
   int other_errors;
   int watchdog_cycles;

   pdes_top dut (
      .clk             (clk),
      .rst_n           (rst_n),
      .start           (start),
      .num_init_events (num_init_events),
      .lp_mask         (lp_mask),
      .fixed_delay     (fixed_delay),
      .sim_end         (sim_end),
      .evt_valid       (evt_valid),
      .evt             (evt),
      .gvt             (gvt),
      .done            (done),
      .busy            (busy),
      .total_events    (total_events),
      .total_cycles    (total_cycles)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // limit set once the case file is read
   initial begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles before all cases finished", watchdog_cycles);
      $display("STATUS: FAIL");
      $finish;
   end

   task automatic check_count(input string name, input pdes_pkg::count_t got,
                              input pdes_pkg::count_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_time(input string name, input pdes_pkg::time_t got,
                             input pdes_pkg::time_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_event(input string name, input pdes_pkg::event_t got,
                              input pdes_pkg::event_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("[FAIL] %s got 0x%h (lp 0x%h ts 0x%h) expected 0x%h (lp 0x%h ts 0x%h)",
                  name, got, got.lp, got.timestamp, exp, exp.lp, exp.timestamp);
      end
   endtask

   task automatic report_problem(input string msg);
      other_errors++;
      $display("[ERROR] %s", msg);
   endtask

   task automatic read_cases();
      int    fd;
      int    fields;
      int    a, b, c, d, e, f;
      string line;
      fd = $fopen("verification/pdes_cases.txt", "r");
      if (fd == 0) begin
         report_problem("cannot open verification/pdes_cases.txt");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         fields = $sscanf(line, "%d %d %d %d %d %d", a, b, c, d, e, f);
         if (fields == 6) begin
            if (a < 1 || a > `PDES_QUEUE_DEPTH || c == 0) begin
               report_problem($sformatf("case line skipped, bad configuration: %s", line));
            end else begin
               cfg_num.push_back(a);
               cfg_mask.push_back(b);
               cfg_delay.push_back(c);
               cfg_end.push_back(d);
               exp_events.push_back(e);
               exp_gvt.push_back(f);
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic run_case(input int ci);
      pdes_pkg::lp_id_t lp_model [`PDES_QUEUE_DEPTH];
      pdes_pkg::event_t exp_evt;
      pdes_pkg::time_t  last_ts;
      int               n;
      int               k;
      int               gap;
      int               seen;
      int               zero_seen;
      int               ts_calc;
      n = cfg_num[ci];
      k = cfg_end[ci] / cfg_delay[ci] + 1;
      if (n * k != exp_events[ci] || k * cfg_delay[ci] != exp_gvt[ci]) begin
         report_problem($sformatf("case %0d expected values do not follow the PHOLD rule", ci));
      end
      // chain i starts at LP i under the mask
      for (int i = 0; i < `PDES_QUEUE_DEPTH; i++) begin
         lp_model[i] = pdes_pkg::lp_id_t'(i) & pdes_pkg::lp_id_t'(cfg_mask[ci]);
      end
      gap = int'($urandom % 8);
      @(posedge clk);
      num_init_events <= pdes_pkg::init_cnt_t'(n);
      lp_mask         <= pdes_pkg::lp_id_t'(cfg_mask[ci]);
      fixed_delay     <= pdes_pkg::time_t'(cfg_delay[ci]);
      sim_end         <= pdes_pkg::time_t'(cfg_end[ci]);
      repeat (gap) @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
      if (!busy) begin
         report_problem($sformatf("case %0d busy did not rise after start", ci));
      end
      seen      = 0;
      zero_seen = 0;
      last_ts   = '0;
      while (!done) begin
         if (evt_valid) begin
            // ties leave in arrival order so chains take turns each round
            ts_calc           = (seen / n) * cfg_delay[ci];
            exp_evt.lp        = lp_model[seen % n];
            exp_evt.timestamp = pdes_pkg::time_t'(ts_calc);
            check_event("evt", evt, exp_evt);
            if (seen > 0 && evt.timestamp < last_ts) begin
               report_problem($sformatf("case %0d timestamp went backward from %0d to %0d",
                                        ci, last_ts, evt.timestamp));
            end
            if (evt.timestamp > sim_end) begin
               report_problem($sformatf("case %0d dispatched time %0d past the end time",
                                        ci, evt.timestamp));
            end
            if ((evt.lp & ~lp_mask) != '0) begin
               report_problem($sformatf("case %0d dispatched LP %0d outside the mask",
                                        ci, evt.lp));
            end
            if (evt.timestamp == '0) begin
               zero_seen++;
            end
            lp_model[seen % n] = (lp_model[seen % n] + 1'b1) & lp_mask;
            last_ts            = evt.timestamp;
            seen++;
         end
         @(negedge clk);
      end
      // done cycle
      check_count("total_events", total_events, pdes_pkg::count_t'(exp_events[ci]));
      check_count("evt_valid pulses", pdes_pkg::count_t'(seen),
                  pdes_pkg::count_t'(exp_events[ci]));
      check_count("time 0 dispatches", pdes_pkg::count_t'(zero_seen), pdes_pkg::count_t'(n));
      check_time("gvt", gvt, pdes_pkg::time_t'(exp_gvt[ci]));
      // two cycles per dispatch, then the past-end take and the end_seen cycle
      check_count("total_cycles", total_cycles, pdes_pkg::count_t'(2 * exp_events[ci] + 2));
      if (busy) begin
         report_problem($sformatf("case %0d busy still high while done is high", ci));
      end
      @(negedge clk);
      if (done) begin
         report_problem($sformatf("case %0d done stayed high for more than one cycle", ci));
      end
      $display("case %0d finished: %0d events, gvt %0d, %0d cycles",
               ci, seen, gvt, total_cycles);
   endtask

   initial begin
      int sum_events;
      rst_n           = 1'b0;
      start           = 1'b0;
      num_init_events = '0;
      lp_mask         = '0;
      fixed_delay     = '0;
      sim_end         = '0;
      value_errors    = 0;
      other_errors    = 0;
      sum_events      = 0;
      void'($urandom(32'h488c_ad87));
      read_cases();
      if (cfg_num.size() == 0) begin
         report_problem("no usable cases in the case file");
      end
      foreach (exp_events[i]) begin
         sum_events += exp_events[i];
      end
      watchdog_cycles = sum_events * 8 + 200;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      // back to back runs with no reset in between
      for (int ci = 0; ci < cfg_num.size(); ci++) begin
         run_case(ci);
      end
      repeat (2) @(posedge clk);
      $display("summary: %0d cases, %0d value errors, %0d other errors",
               cfg_num.size(), value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== hdl/pdes_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module pdes_top (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire                        start,
   input  wire pdes_pkg::init_cnt_t   num_init_events,
   input  wire pdes_pkg::lp_id_t      lp_mask,
   input  wire pdes_pkg::time_t       fixed_delay,
   input  wire pdes_pkg::time_t       sim_end,
   output logic                       evt_valid,
   output pdes_pkg::event_t           evt,
   output pdes_pkg::time_t            gvt,
   output logic                       done,
   output logic                       busy,
   output pdes_pkg::count_t           total_events,
   output pdes_pkg::count_t           total_cycles
);

   pdes_pkg::run_state_e run_state;
   pdes_pkg::event_t     enq_event;
   pdes_pkg::event_t     head_event;
   pdes_pkg::event_t     succ_event;
   pdes_pkg::event_t     dispatch_event;
   logic                 queue_clear;
   logic                 seed_done;
   logic                 enq_valid;
   logic                 enq_ready;
   logic                 head_valid;
   logic                 deq_ready;
   logic                 succ_valid;
   logic                 succ_ready;
   logic                 dispatch_valid;
   logic                 end_seen;

   event_source u_source (
      .clk             (clk),
      .rst_n           (rst_n),
      .run_state       (run_state),
      .num_init_events (num_init_events),
      .lp_mask         (lp_mask),
      .succ_valid      (succ_valid),
      .succ_event      (succ_event),
      .succ_ready      (succ_ready),
      .enq_valid       (enq_valid),
      .enq_event       (enq_event),
      .enq_ready       (enq_ready),
      .seed_done       (seed_done)
   );

   event_queue u_queue (
      .clk        (clk),
      .rst_n      (rst_n),
      .clear      (queue_clear),
      .enq_valid  (enq_valid),
      .enq_event  (enq_event),
      .enq_ready  (enq_ready),
      .head_valid (head_valid),
      .head_event (head_event),
      .deq_ready  (deq_ready)
   );

   event_processor u_proc (
      .clk            (clk),
      .rst_n          (rst_n),
      .run_state      (run_state),
      .lp_mask        (lp_mask),
      .fixed_delay    (fixed_delay),
      .sim_end        (sim_end),
      .head_valid     (head_valid),
      .head_event     (head_event),
      .deq_ready      (deq_ready),
      .succ_valid     (succ_valid),
      .succ_event     (succ_event),
      .succ_ready     (succ_ready),
      .dispatch_valid (dispatch_valid),
      .dispatch_event (dispatch_event),
      .end_seen       (end_seen)
   );

   run_control u_ctrl (
      .clk            (clk),
      .rst_n          (rst_n),
      .start          (start),
      .seed_done      (seed_done),
      .dispatch_valid (dispatch_valid),
      .dispatch_event (dispatch_event),
      .end_seen       (end_seen),
      .run_state      (run_state),
      .queue_clear    (queue_clear),
      .gvt            (gvt),
      .done           (done),
      .busy           (busy),
      .total_events   (total_events),
      .total_cycles   (total_cycles)
   );

   // dispatch stream out to the host
   assign evt_valid = dispatch_valid;
   assign evt       = dispatch_event;

endmodule

`default_nettype wire

// ==== hdl/run_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module run_control (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire                        start,
   input  wire                        seed_done,
   input  wire                        dispatch_valid,
   input  wire pdes_pkg::event_t      dispatch_event,
   input  wire                        end_seen,
   output pdes_pkg::run_state_e       run_state,
   output logic                       queue_clear,
   output pdes_pkg::time_t            gvt,
   output logic                       done,
   output logic                       busy,
   output pdes_pkg::count_t           total_events,
   output pdes_pkg::count_t           total_cycles
);

   pdes_pkg::run_state_e state_d;
   logic                 start_run;

   // start only counts while idle
   assign start_run   = start && (run_state == pdes_pkg::IDLE);
   assign queue_clear = start_run;

   always_comb begin
      state_d = run_state;
      case (run_state)
         pdes_pkg::IDLE: begin
            if (start) begin
               state_d = pdes_pkg::INIT;
            end
         end
         pdes_pkg::INIT: begin
            if (seed_done) begin
               state_d = pdes_pkg::RUNNING;
            end
         end
         pdes_pkg::RUNNING: begin
            if (end_seen) begin
               state_d = pdes_pkg::FINISHED;
            end
         end
         default: begin
            state_d = pdes_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         run_state <= pdes_pkg::IDLE;
      end else begin
         run_state <= state_d;
      end
   end

   // FINISHED lasts one cycle, so done is a single pulse
   assign done = (run_state == pdes_pkg::FINISHED);
   assign busy = (run_state == pdes_pkg::INIT) || (run_state == pdes_pkg::RUNNING);

   // one processor, so GVT is just the last timestamp taken
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gvt          <= '0;
         total_events <= '0;
         total_cycles <= '0;
      end else if (start_run) begin
         gvt          <= '0;
         total_events <= '0;
         total_cycles <= '0;
      end else begin
         if (dispatch_valid || end_seen) begin
            gvt <= dispatch_event.timestamp;
         end
         if (dispatch_valid) begin
            total_events <= total_events + 1'b1;
         end
         if (run_state == pdes_pkg::RUNNING) begin
            total_cycles <= total_cycles + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/event_processor.sv ====
`timescale 1ns/100ps
`default_nettype none

module event_processor (
   input  wire                           clk,
   input  wire                           rst_n,
   input  wire pdes_pkg::run_state_e     run_state,
   input  wire pdes_pkg::lp_id_t         lp_mask,
   input  wire pdes_pkg::time_t          fixed_delay,
   input  wire pdes_pkg::time_t          sim_end,
   input  wire                           head_valid,
   input  wire pdes_pkg::event_t         head_event,
   output logic                          deq_ready,
   output logic                          succ_valid,
   output pdes_pkg::event_t              succ_event,
   input  wire                           succ_ready,
   output logic                          dispatch_valid,
   output pdes_pkg::event_t              dispatch_event,
   output logic                          end_seen
);

   pdes_pkg::event_t next_event;
   logic             take;
   logic             past_end;

   // idle means no successor pending and no end flag going out
   assign deq_ready = (run_state == pdes_pkg::RUNNING) && !succ_valid && !end_seen;
   assign take      = head_valid && deq_ready;
   assign past_end  = head_event.timestamp > sim_end;

   // PHOLD step: next LP, fixed delay later
   always_comb begin
      next_event.lp        = (head_event.lp + 1'b1) & lp_mask;
      next_event.timestamp = head_event.timestamp + fixed_delay;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         succ_valid     <= 1'b0;
         dispatch_valid <= 1'b0;
         end_seen       <= 1'b0;
      end else begin
         dispatch_valid <= take && !past_end;
         end_seen       <= take && past_end;
         if (take && !past_end) begin
            succ_valid <= 1'b1;
         end else if (succ_ready) begin
            succ_valid <= 1'b0;
         end
      end
   end

   // dispatch_event also carries the final head out with end_seen
   always_ff @(posedge clk) begin
      if (take) begin
         dispatch_event <= head_event;
         succ_event     <= next_event;
      end
   end

   // zero delay would pin simulated time and never reach sim_end
   a_delay_nonzero : assert property (
      @(posedge clk) disable iff (!rst_n)
      run_state == pdes_pkg::RUNNING |-> fixed_delay != '0
   ) else $error("fixed_delay is zero while running");

endmodule

`default_nettype wire

// ==== hdl/event_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pdes_macros.svh"

module event_queue (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     clear,
   input  wire                     enq_valid,
   input  wire pdes_pkg::event_t   enq_event,
   output logic                    enq_ready,
   output logic                    head_valid,
   output pdes_pkg::event_t        head_event,
   input  wire                     deq_ready
);

   pdes_pkg::event_t             slot_q [`PDES_QUEUE_DEPTH];
   pdes_pkg::event_t             slot_d [`PDES_QUEUE_DEPTH];
   logic [`PDES_QUEUE_DEPTH-1:0] vld_q;
   logic [`PDES_QUEUE_DEPTH-1:0] ins;
   logic [`PDES_QUEUE_DEPTH-1:0] ins_up;
   logic [`PDES_QUEUE_DEPTH-1:0] ins_dn;
   logic                         enq_fire;
   logic                         deq_fire;

   assign enq_ready  = !vld_q[`PDES_QUEUE_DEPTH-1];
   assign head_valid = vld_q[0];
   assign head_event = slot_q[0];
   assign enq_fire   = enq_valid && enq_ready;
   assign deq_fire   = head_valid && deq_ready;

   // slot at or behind the insert point; strict compare keeps ties in arrival order
   always_comb begin
      for (int i = 0; i < `PDES_QUEUE_DEPTH; i++) begin
         ins[i] = !vld_q[i] || (slot_q[i].timestamp > enq_event.timestamp);
      end
   end

   // insert flags of the neighbors below and above each slot
   assign ins_dn = {ins[`PDES_QUEUE_DEPTH-2:0], 1'b0};
   assign ins_up = {1'b1, ins[`PDES_QUEUE_DEPTH-1:1]};

   always_comb begin
      for (int i = 0; i < `PDES_QUEUE_DEPTH; i++) begin
         slot_d[i] = slot_q[i];
         if (deq_fire) begin
            if (enq_fire && ins_up[i] && (i == 0 || !ins[i])) begin
               slot_d[i] = enq_event;
            end else if (!(enq_fire && ins_up[i])) begin
               // plain shift toward the head
               slot_d[i] = slot_q[(i < `PDES_QUEUE_DEPTH - 1) ? i + 1 : i];
            end
            // otherwise removal and insert cancel out for this slot
         end else if (enq_fire && ins[i]) begin
            slot_d[i] = ins_dn[i] ? slot_q[(i > 0) ? i - 1 : 0] : enq_event;
         end
      end
   end

   always_ff @(posedge clk) begin
      slot_q <= slot_d;
   end

   // valid bits stay a thermometer from the head
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld_q <= '0;
      end else if (clear) begin
         vld_q <= '0;
      end else if (enq_fire && !deq_fire) begin
         vld_q <= {vld_q[`PDES_QUEUE_DEPTH-2:0], 1'b1};
      end else if (deq_fire && !enq_fire) begin
         vld_q <= {1'b0, vld_q[`PDES_QUEUE_DEPTH-1:1]};
      end
   end

   // a full queue with no dequeue keeps its tail, so nothing slipped in
   a_no_enq_when_full : assert property (
      @(posedge clk) disable iff (!rst_n)
      vld_q[`PDES_QUEUE_DEPTH-1] && !deq_fire && !clear
         |=> vld_q[`PDES_QUEUE_DEPTH-1] && $stable(slot_q[`PDES_QUEUE_DEPTH-1])
   ) else $error("enqueue accepted while full");

   a_head_is_min : assert property (
      @(posedge clk) disable iff (!rst_n)
      vld_q[1] |-> slot_q[0].timestamp <= slot_q[1].timestamp
   ) else $error("head timestamp above slot 1");

endmodule

`default_nettype wire

// ==== hdl/event_source.sv ====
`timescale 1ns/100ps
`default_nettype none

module event_source (
   input  wire                           clk,
   input  wire                           rst_n,
   input  wire pdes_pkg::run_state_e     run_state,
   input  wire pdes_pkg::init_cnt_t      num_init_events,
   input  wire pdes_pkg::lp_id_t         lp_mask,
   input  wire                           succ_valid,
   input  wire pdes_pkg::event_t         succ_event,
   output logic                          succ_ready,
   output logic                          enq_valid,
   output pdes_pkg::event_t              enq_event,
   input  wire                           enq_ready,
   output logic                          seed_done
);

   pdes_pkg::init_cnt_t seed_cnt;
   pdes_pkg::event_t    seed_event;
   logic                seeding;
   logic                seed_fire;

   // seeds still owed in this run
   assign seeding   = (run_state == pdes_pkg::INIT) && (seed_cnt != num_init_events);
   assign seed_fire = seeding && enq_ready;

   // seed n goes to LP n at time 0
   always_comb begin
      seed_event.lp        = pdes_pkg::lp_id_t'(seed_cnt) & lp_mask;
      seed_event.timestamp = '0;
   end

   // queue input: seeds in INIT, processor successors in RUNNING
   always_comb begin
      if (run_state == pdes_pkg::INIT) begin
         enq_valid = seeding;
         enq_event = seed_event;
      end else begin
         enq_valid = (run_state == pdes_pkg::RUNNING) && succ_valid;
         enq_event = succ_event;
      end
   end

   assign succ_ready = (run_state == pdes_pkg::RUNNING) && enq_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         seed_cnt  <= '0;
         seed_done <= 1'b0;
      end else begin
         if (run_state != pdes_pkg::INIT) begin
            seed_cnt <= '0;
         end else if (seed_fire) begin
            seed_cnt <= seed_cnt + 1'b1;
         end
         // one cycle after the last seed is taken
         seed_done <= seed_fire && ((seed_cnt + 1'b1) == num_init_events);
      end
   end

   // processor stays quiet until the queue is seeded
   a_no_succ_in_init : assert property (
      @(posedge clk) disable iff (!rst_n)
      run_state == pdes_pkg::INIT |-> !succ_valid
   ) else $error("successor offered during INIT");

endmodule

`default_nettype wire

// ==== hdl/pdes_pkg.sv ====
`default_nettype none

`include "pdes_macros.svh"

package pdes_pkg;

   // simulation time
   typedef logic [`PDES_TIME_WID-1:0] time_t;

   // logical-process number
   typedef logic [`PDES_LP_WID-1:0] lp_id_t;

   // number of seeds for a run
   typedef logic [`PDES_INIT_WID-1:0] init_cnt_t;

   // event and cycle statistics
   typedef logic [`PDES_COUNT_WID-1:0] count_t;

   // one event: target LP in the upper bits, timestamp below
   typedef struct packed {
      lp_id_t lp;
      time_t  timestamp;
   } event_t;

   // engine run phases
   typedef enum logic [1:0] {
      IDLE     = 2'd0,
      INIT     = 2'd1,
      RUNNING  = 2'd2,
      FINISHED = 2'd3
   } run_state_e;

endpackage

`default_nettype wire

// ==== hdl/pdes_macros.svh ====
`ifndef PDES_MACROS_SVH
`define PDES_MACROS_SVH

// simulation timestamp width
`define PDES_TIME_WID 16

// logical-process number width
`define PDES_LP_WID 8

// queue slots; also the largest initial event count
`define PDES_QUEUE_DEPTH 16

// initial event count width, holds 0 to PDES_QUEUE_DEPTH
`define PDES_INIT_WID 5

// statistics counter width
`define PDES_COUNT_WID 32

`endif
